// File: crc_ahb_bus_pkg.sv
// AHB-Lite encodings for one slave; only NON_SEQ transfers act and HRESP never leaves OK
`default_nettype none

package crc_ahb_bus_pkg;

	// HTRANS transfer types
	typedef enum logic [1:0]
	{
		IDLE    = 2'b00,
		BUSY    = 2'b01,
		NON_SEQ = 2'b10,
		SEQ     = 2'b11
	} htrans_e;

	// Slave response
	typedef enum logic
	{
		OK    = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Word offsets as seen on HADDR[4:2]
	typedef enum logic [2:0]
	{
		CRC_DR   = 3'h0,
		CRC_IDR  = 3'h1,
		CRC_CR   = 3'h2,
		CRC_INIT = 3'h4,
		CRC_POL  = 3'h5
	} reg_addr_e;

endpackage

`default_nettype wire

// File: crc_ahb_cfg_pkg.sv
// CRC configuration encodings; CR fields sit at bits 7..3 and reset values follow the register map
`default_nettype none

package crc_ahb_cfg_pkg;

	// CR[4:3] polynomial width
	typedef enum logic [1:0]
	{
		POLY32 = 2'b00,
		POLY16 = 2'b01,
		POLY8  = 2'b10,
		POLY7  = 2'b11
	} poly_size_e;

	// CR[6:5] input bit reversal
	typedef enum logic [1:0]
	{
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_e;

	// HSIZE[1:0] of a DR write
	typedef enum logic [1:0]
	{
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} bus_size_e;

	// Data word, whole for reversal, by byte lane when shifting
	typedef union packed
	{
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} crc_word_u;

	// Reset values
	localparam logic [4:0]  RESET_CRC_CR = 5'h00;
	localparam logic [31:0] RESET_INIT   = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POLY   = 32'h04C1_1DB7;

endpackage

`default_nettype wire

// File: host_interface.sv
// Single-master AHB-Lite slave decoding only HADDR[4:2] without burst checks and with HRESP always OK
`timescale 1ns/1ps
`default_nettype none

module host_interface
(
	input  wire                                HCLK,
	input  wire                                HRESETn,
	input  wire                                HSElx,
	input  wire [31:0]                         HADDR,
	input  wire [1:0]                          HTRANS,
	input  wire [2:0]                          HSIZE,
	input  wire                                HWRITE,
	input  wire [31:0]                         HWDATA,
	input  wire                                HREADY,
	input  wire                                buffer_full,
	input  wire                                reset_pending,
	input  wire                                read_wait,
	input  wire [31:0]                         crc_out,
	input  wire [31:0]                         crc_init_out,
	input  wire [7:0]                          crc_idr_out,
	input  wire [31:0]                         crc_poly_out,
	output logic [31:0]                        HRDATA,
	output logic                               HREADYOUT,
	output crc_ahb_bus_pkg::hresp_e            HRESP,
	output logic [31:0]                        bus_wr,
	output crc_ahb_cfg_pkg::bus_size_e         bus_size,
	output logic                               buffer_write_en,
	output logic                               crc_init_en,
	output logic                               crc_idr_en,
	output logic                               crc_poly_en,
	output logic                               reset_chain,
	output crc_ahb_cfg_pkg::poly_size_e        crc_poly_size,
	output crc_ahb_cfg_pkg::rev_in_e           rev_in_type,
	output logic                               rev_out_type
);
	import crc_ahb_bus_pkg::*;
	import crc_ahb_cfg_pkg::*;

	// Address phase held into the data phase
	logic       hsel_pp;
	logic       hwrite_pp;
	htrans_e    htrans_pp;
	reg_addr_e  haddr_pp;
	logic [1:0] hsize_pp;

	// CR bits 7..3
	logic [4:0] crc_cr_q;

	logic sample_bus;
	logic write_en;
	logic read_en;
	logic dr_wr;
	logic dr_rd;
	logic idr_wr;
	logic cr_wr;
	logic init_wr;
	logic poly_wr;
	logic chain_wr;
	logic stall;

	////////////////////////////////////////
	// Address phase
	////////////////////////////////////////

	assign sample_bus = HREADYOUT && HREADY;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_pp   <= 1'b0;
			hwrite_pp <= 1'b0;
			htrans_pp <= IDLE;
		end
		else if (sample_bus)
		begin
			hsel_pp   <= HSElx;
			hwrite_pp <= HWRITE;
			htrans_pp <= htrans_e'(HTRANS);
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= reg_addr_e'(HADDR[4:2]);
			hsize_pp <= HSIZE[1:0];
		end
	end

	////////////////////////////////////////
	// Decode and stall
	////////////////////////////////////////

	// Only NON_SEQ acts while SEQ and BUSY are ignored
	assign write_en = hsel_pp && hwrite_pp && (htrans_pp == NON_SEQ);
	assign read_en  = hsel_pp && !hwrite_pp && (htrans_pp == NON_SEQ);

	assign dr_wr    = write_en && (haddr_pp == CRC_DR);
	assign dr_rd    = read_en && (haddr_pp == CRC_DR);
	assign idr_wr   = write_en && (haddr_pp == CRC_IDR);
	assign cr_wr    = write_en && (haddr_pp == CRC_CR);
	assign init_wr  = write_en && (haddr_pp == CRC_INIT);
	assign poly_wr  = write_en && (haddr_pp == CRC_POL);
	// CR bit 0 requests a CRC reload from INIT
	assign chain_wr = cr_wr && HWDATA[0];

	// Wait on a full buffer, on a DR read before the CRC settles and on a reload before data drains
	assign stall = (dr_wr && buffer_full) ||
	               (dr_rd && read_wait) ||
	               ((init_wr || chain_wr) && reset_pending);

	assign HREADYOUT = !stall;
	assign HRESP     = OK;

	// Strobes fire only on the edge that ends the data phase
	assign buffer_write_en = dr_wr && HREADYOUT;
	assign crc_init_en     = init_wr && HREADYOUT;
	assign crc_idr_en      = idr_wr && HREADYOUT;
	assign crc_poly_en     = poly_wr && HREADYOUT;
	assign reset_chain     = chain_wr && HREADYOUT;

	// Write data comes straight from the bus and size from the address phase
	assign bus_wr   = HWDATA;
	assign bus_size = bus_size_e'(hsize_pp);

	// Control register
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_q <= RESET_CRC_CR;
		else if (cr_wr && HREADYOUT)
			crc_cr_q <= HWDATA[7:3];
	end

	assign crc_poly_size = poly_size_e'(crc_cr_q[1:0]);
	assign rev_in_type   = rev_in_e'(crc_cr_q[3:2]);
	assign rev_out_type  = crc_cr_q[4];

	// Read mux on the held offset where unmapped offsets read zero
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, crc_cr_q, 3'h0};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

	// A full buffer always counts as pending work for DR reads and reloads
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_full |-> read_wait && reset_pending);

	// Sampled transfer that is not a selected NON_SEQ write gives no strobe
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(sample_bus && !(HSElx && HWRITE && (HTRANS == NON_SEQ))) |=>
		!(buffer_write_en || crc_init_en || crc_idr_en || crc_poly_en || reset_chain));

endmodule

`default_nettype wire

// File: crc_data_buffer.sv
// DR write FIFO; BUF_DEPTH must be a power of two, 2 or more, and no push may arrive while full
`timescale 1ns/1ps
`default_nettype none

module crc_data_buffer
#(
	parameter int BUF_DEPTH = 2
)
(
	input  wire                              HCLK,
	input  wire                              HRESETn,
	input  wire                              buffer_write_en,
	input  wire [31:0]                       bus_wr,
	input  wire crc_ahb_cfg_pkg::bus_size_e  bus_size,
	input  wire                              buf_pop,
	output logic                             buffer_full,
	output logic                             buf_valid,
	output logic [31:0]                      buf_data,
	output crc_ahb_cfg_pkg::bus_size_e       buf_size
);
	import crc_ahb_cfg_pkg::*;

	localparam int PTR_W = $clog2(BUF_DEPTH);

	// Entry storage, word plus transfer size
	logic [31:0]      mem_data [BUF_DEPTH];
	bus_size_e        mem_size [BUF_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Occupancy, one bit wider than the pointers
	logic [PTR_W:0]   count;

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (buffer_write_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (buf_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop on one edge leave the count alone
			case ({buffer_write_en, buf_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			mem_data[wr_ptr] <= bus_wr;
			mem_size[wr_ptr] <= bus_size;
		end
	end

	assign buffer_full = (count == (PTR_W + 1)'(BUF_DEPTH));
	assign buf_valid   = (count != '0);
	// Head entry, shown while valid
	assign buf_data    = mem_data[rd_ptr];
	assign buf_size    = mem_size[rd_ptr];

	// Host interface holds a DR write while full
	assert property (@(posedge HCLK) disable iff (!HRESETn) buffer_full |-> !buffer_write_en);

	// Engine only takes an entry that exists
	assert property (@(posedge HCLK) disable iff (!HRESETn) buf_pop |-> buf_valid);

endmodule

`default_nettype wire

// File: crc_unit.sv
// Byte-serial CRC taking the low byte first; byte and half writes use the low lanes and reversal stays inside them
`timescale 1ns/1ps
`default_nettype none

module crc_unit
(
	input  wire                               HCLK,
	input  wire                               HRESETn,
	input  wire                               buf_valid,
	input  wire [31:0]                        buf_data,
	input  wire crc_ahb_cfg_pkg::bus_size_e   buf_size,
	input  wire                               crc_init_en,
	input  wire                               crc_idr_en,
	input  wire                               crc_poly_en,
	input  wire                               reset_chain,
	input  wire [31:0]                        bus_wr,
	input  wire crc_ahb_cfg_pkg::poly_size_e  crc_poly_size,
	input  wire crc_ahb_cfg_pkg::rev_in_e     rev_in_type,
	input  wire                               rev_out_type,
	output logic                              buf_pop,
	output logic                              busy,
	output logic [31:0]                       crc_out,
	output logic [31:0]                       crc_init_out,
	output logic [7:0]                        crc_idr_out,
	output logic [31:0]                       crc_poly_out
);
	import crc_ahb_cfg_pkg::*;

	logic [31:0] init_q;
	logic [31:0] poly_q;
	logic [7:0]  idr_q;
	// Running CRC right aligned
	logic [31:0] crc_q;
	crc_word_u   data_q;
	logic        active_q;
	logic [1:0]  byte_idx;
	logic [1:0]  byte_last;
	// 32 minus the polynomial width
	logic [5:0]  pad;
	logic [31:0] crc_next;

	////////////////////////////////////////
	// Bit helpers
	////////////////////////////////////////

	// Reverse bits inside lanes of 8, 16 or 32
	function automatic logic [31:0] rev_lanes(input logic [31:0] d, input int lane);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i / lane) * lane + lane - 1 - (i % lane)];
		return r;
	endfunction

	// Lane never wider than the transfer
	function automatic logic [31:0] rev_input(input logic [31:0] d, input rev_in_e mode,
		input bus_size_e size);
		logic [31:0] r;
		r = d;
		if (mode == REV_BYTE || (mode != REV_NONE && size == SIZE_BYTE))
			r = rev_lanes(d, 8);
		else if (mode == REV_HALF || (mode == REV_WORD && size == SIZE_HALF))
			r = rev_lanes(d, 16);
		else if (mode == REV_WORD)
			r = rev_lanes(d, 32);
		return r;
	endfunction

	// One byte MSB first with the CRC left aligned so all widths share the taps
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [31:0] poly,
		input logic [7:0] d, input logic [5:0] sh);
		logic [31:0] c;
		logic [31:0] p;
		logic        fb;
		c = crc << sh;
		p = poly << sh;
		for (int j = 7; j >= 0; j--)
		begin
			fb = c[31] ^ d[j];
			c  = c << 1;
			if (fb)
				c = c ^ p;
		end
		return c >> sh;
	endfunction

	always_comb
	begin
		case (crc_poly_size)
			POLY16:  pad = 6'd16;
			POLY8:   pad = 6'd24;
			POLY7:   pad = 6'd25;
			default: pad = 6'd0;
		endcase
	end

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	// Take a word only when idle
	assign buf_pop  = buf_valid && !active_q;
	// Work pending in the buffer or in the shifter
	assign busy     = active_q || buf_valid;
	assign crc_next = crc_byte(crc_q, poly_q, data_q.bytes[byte_idx], pad);

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			active_q  <= 1'b0;
			byte_idx  <= 2'd0;
			byte_last <= 2'd0;
		end
		else if (buf_pop)
		begin
			active_q <= 1'b1;
			byte_idx <= 2'd0;
			case (buf_size)
				SIZE_BYTE: byte_last <= 2'd0;
				SIZE_HALF: byte_last <= 2'd1;
				default:   byte_last <= 2'd3;
			endcase
		end
		else if (active_q)
		begin
			if (byte_idx == byte_last)
				active_q <= 1'b0;
			byte_idx <= byte_idx + 2'd1;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (buf_pop)
			data_q.word <= rev_input(buf_data, rev_in_type, buf_size);
	end

	// Registers and running CRC where a reload wins over shifting
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= RESET_INIT;
			poly_q <= RESET_POLY;
			idr_q  <= 8'h00;
			crc_q  <= RESET_INIT;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
			if (crc_init_en)
				crc_q <= bus_wr;
			else if (reset_chain)
				crc_q <= init_q;
			else if (active_q)
				crc_q <= crc_next;
		end
	end

	// Masked to the width and optionally mirrored across it
	assign crc_out      = rev_out_type ? (rev_lanes(crc_q, 32) >> pad) : ((crc_q << pad) >> pad);
	assign crc_init_out = init_q;
	assign crc_poly_out = poly_q;
	assign crc_idr_out  = idr_q;

	// Reloads arrive only once queued and shifting data has been absorbed
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(crc_init_en || reset_chain) |-> !busy);

endmodule

`default_nettype wire

// File: crc_ahb_top.sv
// CRC slave on one AHB-Lite bus and one clock; BUF_DEPTH must be a power of two, 2 or more
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_top
#(
	parameter int BUF_DEPTH = 2
)
(
	input  wire                        HCLK,
	input  wire                        HRESETn,
	input  wire                        HSElx,
	input  wire [31:0]                 HADDR,
	input  wire [1:0]                  HTRANS,
	input  wire [2:0]                  HSIZE,
	input  wire                        HWRITE,
	input  wire [31:0]                 HWDATA,
	input  wire                        HREADY,
	output logic [31:0]                HRDATA,
	output logic                       HREADYOUT,
	output crc_ahb_bus_pkg::hresp_e    HRESP
);
	import crc_ahb_cfg_pkg::*;

	// Host interface to buffer and engine
	logic [31:0] bus_wr;
	bus_size_e   bus_size;
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        reset_chain;
	poly_size_e  crc_poly_size;
	rev_in_e     rev_in_type;
	logic        rev_out_type;

	// Buffer to engine
	logic        buffer_full;
	logic        buf_valid;
	logic [31:0] buf_data;
	bus_size_e   buf_size;
	logic        buf_pop;

	// Engine back to host interface
	logic        busy;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [7:0]  crc_idr_out;
	logic [31:0] crc_poly_out;

	// Pending work gates both DR reads and CRC reloads
	host_interface u_host_interface
	(
		.read_wait     (busy),
		.reset_pending (busy),
		.*
	);

	crc_data_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_crc_data_buffer
	(
		.*
	);

	crc_unit u_crc_unit
	(
		.*
	);

endmodule

`default_nettype wire

// File: crc_tb_clock.sv
// Testbench clock and reset only; reset stays low for RESET_CYCLES edges, then rises 1 ns later
`timescale 1ns/1ps
`default_nettype none

module crc_tb_clock
#(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
)
(
	output logic HCLK,
	output logic HRESETn
);

	// Free-running clock
	initial
	begin
		HCLK = 1'b0;
		forever #(PERIOD_NS / 2) HCLK = ~HCLK;
	end

	// Synchronous reset held over the first rising edges
	initial
	begin
		HRESETn = 1'b0;
		repeat (RESET_CYCLES) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;
	end

endmodule

`default_nettype wire

// File: crc_ahb_tb.sv
// Single master on one slave, HREADY tied high; stops at the first mismatch or after the cycle limit
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_tb;
	import crc_ahb_bus_pkg::*;
	import crc_ahb_cfg_pkg::*;

	localparam int BUF_DEPTH = 2;
	localparam int MAX_TESTS = 128;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	hresp_e      HRESP;

	// Test table, one bus transfer per entry
	string       t_name  [MAX_TESTS];
	bit          t_write [MAX_TESTS];
	reg_addr_e   t_off   [MAX_TESTS];
	bus_size_e   t_size  [MAX_TESTS];
	logic [31:0] t_data  [MAX_TESTS];
	logic [31:0] t_exp   [MAX_TESTS];
	bit          t_model [MAX_TESTS];
	bit          t_stall [MAX_TESTS];
	int          n_tests = 0;

	logic [31:0] lcg_q = 32'h88fd;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	// Reference model state
	logic [31:0] m_crc;
	logic [31:0] m_init;
	logic [31:0] m_poly;
	logic [4:0]  m_cfg;

	crc_tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clock
	(
		.HCLK    (HCLK),
		.HRESETn (HRESETn)
	);

	crc_ahb_top #(.BUF_DEPTH(BUF_DEPTH)) UUT
	(
		.*
	);

	////////////////////////////////////////
	// Reference CRC
	////////////////////////////////////////

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Low w bits mirrored, the rest cleared
	function automatic logic [31:0] mirror(input logic [31:0] v, input int w);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < w; i++)
			r[i] = v[w - 1 - i];
		return r;
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	// CR[4:3] seen as cfg[1:0]
	function automatic int poly_width(input logic [4:0] cfg);
		case (poly_size_e'(cfg[1:0]))
			POLY16:  return 16;
			POLY8:   return 8;
			POLY7:   return 7;
			default: return 32;
		endcase
	endfunction

	// One DR write, reversal unit never wider than the transfer
	function automatic logic [31:0] ref_crc_update(input logic [31:0] crc,
		input logic [31:0] poly, input logic [4:0] cfg, input logic [31:0] data,
		input bus_size_e size);
		int          nbits;
		int          lane;
		int          w;
		logic [31:0] mask;
		logic [31:0] d;
		logic [31:0] c;
		logic        fb;
		nbits = (size == SIZE_BYTE) ? 8 : ((size == SIZE_HALF) ? 16 : 32);
		case (rev_in_e'(cfg[3:2]))
			REV_BYTE: lane = 8;
			REV_HALF: lane = 16;
			REV_WORD: lane = 32;
			default:  lane = 0;
		endcase
		if (lane > nbits)
			lane = nbits;
		d = data & width_mask(nbits);
		if (lane != 0)
		begin
			c = d;
			d = '0;
			for (int k = 0; k < nbits; k += lane)
				d = d | (mirror(c >> k, lane) << k);
		end
		w    = poly_width(cfg);
		mask = width_mask(w);
		c    = crc & mask;
		// Low byte first, each byte MSB first
		for (int b = 0; b < nbits; b += 8)
			for (int j = 7; j >= 0; j--)
			begin
				fb = c[w - 1] ^ d[b + j];
				c  = (c << 1) & mask;
				if (fb)
					c = c ^ (poly & mask);
			end
		return c;
	endfunction

	function automatic logic [31:0] ref_crc_out(input logic [31:0] crc, input logic [4:0] cfg);
		int w;
		w = poly_width(cfg);
		if (cfg[4])
			return mirror(crc, w);
		else
			return crc & width_mask(w);
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("Fail %s expected %08h actual %08h", name, exp, act);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic compare_idr(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("Fail %s expected %02h actual %02h", name, exp, act);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic compare_resp(input string name, input hresp_e exp, input hresp_e act);
		if (act !== exp)
		begin
			$display("Fail %s expected %s actual %s", name, exp.name(), act.name());
			$display("tests failed");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////
	// Table building
	////////////////////////////////////////

	task automatic add_entry(input string name, input bit wr, input reg_addr_e off,
		input bus_size_e size, input logic [31:0] data, input logic [31:0] exp,
		input bit use_model, input bit chk_stall);
		t_name[n_tests]  = name;
		t_write[n_tests] = wr;
		t_off[n_tests]   = off;
		t_size[n_tests]  = size;
		t_data[n_tests]  = data;
		t_exp[n_tests]   = exp;
		t_model[n_tests] = use_model;
		t_stall[n_tests] = chk_stall;
		n_tests++;
	endtask

	task automatic add_write(input string name, input reg_addr_e off, input logic [31:0] data);
		add_entry(name, 1'b1, off, SIZE_WORD, data, 32'h0, 1'b0, 1'b0);
	endtask

	task automatic add_read(input string name, input reg_addr_e off, input logic [31:0] exp);
		add_entry(name, 1'b0, off, SIZE_WORD, 32'h0, exp, 1'b0, 1'b0);
	endtask

	// DR writes with LCG data, upper lanes left dirty on narrow sizes
	task automatic add_dr(input string name, input int n, input bus_size_e size);
		for (int i = 0; i < n; i++)
		begin
			lcg_q = lcg_step(lcg_q);
			add_entry(name, 1'b1, CRC_DR, size, lcg_q, 32'h0, 1'b0, 1'b0);
		end
	endtask

	// POL, then CR with reload, then mixed DR writes and a model read
	task automatic add_group(input string name, input logic [7:0] cr, input logic [31:0] poly,
		input int n_byte, input int n_half, input int n_word);
		add_write(name, CRC_POL, poly);
		add_write(name, CRC_CR, {24'h0, cr});
		add_dr(name, n_byte, SIZE_BYTE);
		add_dr(name, n_half, SIZE_HALF);
		add_dr(name, n_word, SIZE_WORD);
		add_entry(name, 1'b0, CRC_DR, SIZE_WORD, 32'h0, 32'h0, 1'b1, 1'b0);
	endtask

	task automatic build_table();
		add_read("reset_cr", CRC_CR, 32'h0);
		add_read("reset_idr", CRC_IDR, 32'h0);
		add_read("reset_init", CRC_INIT, 32'hFFFF_FFFF);
		add_read("reset_pol", CRC_POL, 32'h04C1_1DB7);
		add_read("reset_dr", CRC_DR, 32'hFFFF_FFFF);
		add_write("regs_idr", CRC_IDR, 32'h1234_56A5);
		add_read("regs_idr", CRC_IDR, 32'h0000_00A5);
		add_write("regs_init", CRC_INIT, 32'hCAFE_F00D);
		add_read("regs_init", CRC_INIT, 32'hCAFE_F00D);
		add_write("regs_pol", CRC_POL, 32'h0000_8005);
		add_read("regs_pol", CRC_POL, 32'h0000_8005);
		add_write("regs_cr", CRC_CR, 32'h0000_00FA);
		add_read("regs_cr", CRC_CR, 32'h0000_00F8);
		add_write("regs_restore", CRC_CR, 32'h0);
		add_write("regs_restore", CRC_INIT, 32'hFFFF_FFFF);
		add_write("regs_restore", CRC_POL, 32'h04C1_1DB7);
		add_write("crc32_words", CRC_CR, 32'h1);
		add_dr("crc32_words", 16, SIZE_WORD);
		add_entry("crc32_words", 1'b0, CRC_DR, SIZE_WORD, 32'h0, 32'h0, 1'b1, 1'b0);
		// CR value is {rev_out, rev_in, poly_size, 000} with bit 0 set for reload
		add_group("poly16_rev_byte", 8'hA9, 32'h0000_1021, 1, 3, 0);
		add_group("poly8_rev_half", 8'h51, 32'h0000_0007, 3, 1, 0);
		add_group("poly7_rev_word", 8'hF9, 32'h0000_0009, 1, 2, 1);
		add_group("poly32_rev_none", 8'h81, 32'h04C1_1DB7, 2, 1, 1);
		add_group("poly32_rev_word", 8'h61, 32'h04C1_1DB7, 0, 1, 2);
		add_write("back_to_back", CRC_CR, 32'h1);
		add_dr("back_to_back", BUF_DEPTH + 4, SIZE_WORD);
		add_entry("back_to_back", 1'b0, CRC_DR, SIZE_WORD, 32'h0, 32'h0, 1'b1, 1'b1);
		add_dr("reload", 2, SIZE_WORD);
		add_write("reload", CRC_CR, 32'h1);
		add_read("reload", CRC_DR, 32'hFFFF_FFFF);
		add_dr("init_pending", 2, SIZE_HALF);
		add_write("init_pending", CRC_INIT, 32'h5A5A_C3C3);
		add_read("init_pending", CRC_DR, 32'h5A5A_C3C3);
		add_read("init_pending", CRC_INIT, 32'h5A5A_C3C3);
	endtask

	////////////////////////////////////////
	// Bus driver
	////////////////////////////////////////

	// Entered and left 1 ns after a rising edge
	task automatic run_transfer(input bit wr, input reg_addr_e off, input bus_size_e size,
		input logic [31:0] data, output logic [31:0] rdata, output hresp_e resp,
		output int stalls);
		stalls = 0;
		HSElx  = 1'b1;
		HADDR  = {27'h0, off, 2'b00};
		HTRANS = NON_SEQ;
		HSIZE  = {1'b0, size};
		HWRITE = wr;
		// Address is taken on an edge with HREADYOUT high
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		@(posedge HCLK);
		#1;
		HSElx  = 1'b0;
		HTRANS = IDLE;
		HWRITE = 1'b0;
		HWDATA = data;
		// Data phase, held through wait states
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			stalls++;
			@(negedge HCLK);
		end
		rdata = HRDATA;
		resp  = HRESP;
		@(posedge HCLK);
		#1;
	endtask

	task automatic apply_model_write(input reg_addr_e off, input logic [31:0] data,
		input bus_size_e size);
		case (off)
			CRC_DR:   m_crc = ref_crc_update(m_crc, m_poly, m_cfg, data, size);
			CRC_CR:
			begin
				m_cfg = data[7:3];
				if (data[0])
					m_crc = m_init;
			end
			CRC_INIT:
			begin
				m_init = data;
				m_crc  = data;
			end
			CRC_POL:  m_poly = data;
			default:  m_poly = m_poly;
		endcase
	endtask

	// Cycle limit, set once the table is known
	always @(posedge HCLK)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout after %0d cycles with the test table unfinished", cycle_count);
			$display("tests failed");
			$fatal(1);
		end
	end

	initial
	begin
		logic [31:0] rdata;
		logic [31:0] exp;
		hresp_e      resp;
		int          stalls;
		int          wr_stalls;
		HSElx     = 1'b0;
		HADDR     = 32'h0;
		HTRANS    = IDLE;
		HSIZE     = 3'h0;
		HWRITE    = 1'b0;
		HWDATA    = 32'h0;
		HREADY    = 1'b1;
		m_crc     = RESET_INIT;
		m_init    = RESET_INIT;
		m_poly    = RESET_POLY;
		m_cfg     = RESET_CRC_CR;
		wr_stalls = 0;
		build_table();
		cycle_limit = n_tests * 40 + 10;
		wait (HRESETn === 1'b1);
		for (int i = 0; i < n_tests; i++)
		begin
			// Write stalls are counted per test name
			if (i == 0 || t_name[i] != t_name[i - 1])
				wr_stalls = 0;
			run_transfer(t_write[i], t_off[i], t_size[i], t_data[i], rdata, resp, stalls);
			compare_resp(t_name[i], OK, resp);
			if (t_write[i])
			begin
				wr_stalls += stalls;
				apply_model_write(t_off[i], t_data[i], t_size[i]);
			end
			else
			begin
				exp = t_model[i] ? ref_crc_out(m_crc, m_cfg) : t_exp[i];
				if (t_off[i] == CRC_IDR)
				begin
					compare_idr(t_name[i], exp[7:0], rdata[7:0]);
					compare_word(t_name[i], 32'h0, {rdata[31:8], 8'h00});
				end
				else
					compare_word(t_name[i], exp, rdata);
				if (t_stall[i] && wr_stalls == 0)
				begin
					$display("Writes in %s never saw a wait state", t_name[i]);
					$display("tests failed");
					$fatal(1);
				end
			end
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: crc_ahb.f
crc_ahb_bus_pkg.sv
crc_ahb_cfg_pkg.sv
host_interface.sv
crc_data_buffer.sv
crc_unit.sv
crc_ahb_top.sv
crc_tb_clock.sv
crc_ahb_tb.sv

// File: Makefile
TOP = crc_ahb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f crc_ahb.f -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
